// ==== compile.f ====
radio_ctrl_pkg.sv
db_setting_regs.sv
atr_select.sv
db_readback.sv
db_slot.sv
fp_gpio_mux.sv
radio_ctrl_core.sv
radio_ctrl_checker.sv
tb_radio_ctrl_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and decide from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_radio_ctrl_core \
   -f compile.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "Verification passed" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== tb_radio_ctrl_core.sv ====
`timescale 1ns/1ps

module tb_radio_ctrl_core;
   import radio_ctrl_pkg::*;

   localparam int NCH          = NUM_DBOARDS * CHANS_PER_DBOARD;
   localparam int RESET_CYCLES = 4;
   localparam int ATR_RUNS     = 40;
   localparam int PLAIN_CYCLES = 60;
   localparam int RB_CYCLES    = 60;
   localparam int FP_RUNS      = 30;
   localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 8 + 3 * ATR_RUNS + PLAIN_CYCLES + 3
                                 + RB_CYCLES + 3 + 4 * FP_RUNS;
   localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

   logic        radio_clk;
   logic        rst_n;
   logic        set_stb [NUM_DBOARDS];
   set_addr_t   set_addr [NUM_DBOARDS];
   set_data_t   set_data [NUM_DBOARDS];
   logic        rb_stb [NUM_DBOARDS];
   set_addr_t   rb_addr [NUM_DBOARDS];
   logic        rb_ack [NUM_DBOARDS];
   set_data_t   rb_data [NUM_DBOARDS];
   set_data_t   misc_in [NUM_DBOARDS];
   set_data_t   misc_out [NUM_DBOARDS];
   gpio_t       db_gpio_in [NUM_DBOARDS];
   gpio_t       db_gpio_out [NUM_DBOARDS];
   gpio_t       db_gpio_ddr [NUM_DBOARDS];
   led_t        leds [NUM_DBOARDS];
   logic        run_rx [NCH];
   logic        run_tx [NCH];
   gpio_t       fp_gpio_in;
   gpio_t       fp_gpio_out;
   gpio_t       fp_gpio_ddr;
   logic        core_set_stb;
   set_addr_t   core_set_addr;
   set_data_t   core_set_data;
   logic [15:0] lfsr_state = 16'd65;
   int          cycle_count = 0;
   int          errors;
   int          checks;
   int          tests_run = 0;
   int          errors_mark = 0;
   int          checks_mark = 0;

   radio_ctrl_core #(
      .SR_BASE(SR_DB_BASE), .RB_BASE(RB_DB_BASE), .FP_PINS(FP_GPIO_PINS)
   ) radio_ctrl_core_inst (
      .radio_clk(radio_clk), .i_rst_n(rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_rb_stb(rb_stb), .i_rb_addr(rb_addr), .o_rb_stb(rb_ack), .o_rb_data(rb_data),
      .i_misc_in(misc_in), .o_misc_out(misc_out),
      .i_db_gpio_in(db_gpio_in), .o_db_gpio_out(db_gpio_out), .o_db_gpio_ddr(db_gpio_ddr),
      .o_leds(leds), .i_run_rx(run_rx), .i_run_tx(run_tx),
      .i_fp_gpio_in(fp_gpio_in), .o_fp_gpio_out(fp_gpio_out), .o_fp_gpio_ddr(fp_gpio_ddr),
      .i_core_set_stb(core_set_stb), .i_core_set_addr(core_set_addr),
      .i_core_set_data(core_set_data)
   );

   radio_ctrl_checker #(
      .SR_BASE(SR_DB_BASE), .RB_BASE(RB_DB_BASE), .FP_PINS(FP_GPIO_PINS)
   ) radio_ctrl_checker_inst (
      .radio_clk(radio_clk), .i_rst_n(rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_rb_stb(rb_stb), .i_rb_addr(rb_addr), .i_misc_in(misc_in),
      .i_db_gpio_in(db_gpio_in), .i_run_rx(run_rx), .i_run_tx(run_tx),
      .i_fp_gpio_in(fp_gpio_in), .i_core_set_stb(core_set_stb),
      .i_core_set_addr(core_set_addr), .i_core_set_data(core_set_data),
      .i_dut_rb_stb(rb_ack), .i_dut_rb_data(rb_data), .i_dut_misc_out(misc_out),
      .i_dut_gpio_out(db_gpio_out), .i_dut_gpio_ddr(db_gpio_ddr), .i_dut_leds(leds),
      .i_dut_fp_out(fp_gpio_out), .i_dut_fp_ddr(fp_gpio_ddr),
      .o_errors(errors), .o_checks(checks)
   );

   initial begin
      radio_clk = 1'b0;
      forever #5 radio_clk = ~radio_clk;
   end

   always @(posedge radio_clk) cycle_count <= cycle_count + 1;

   initial begin
      wait (cycle_count >= TIMEOUT_CYCLES);
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // fibonacci lfsr on x^16 + x^14 + x^13 + x^11 + 1
   // ------------------------------------------------------------------------
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic set_addr_t atr_offset(input int r);
      return (r < 4) ? SR_GPIO_IDLE + set_addr_t'(r) : SR_LED_IDLE + set_addr_t'(r - 4);
   endfunction

   task automatic clear_strobes();
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         set_stb[s] = 1'b0;
         rb_stb[s]  = 1'b0;
      end
      core_set_stb = 1'b0;
   endtask

   task automatic set_run_flags(input logic [31:0] v);
      for (int i = 0; i < NCH; i++) begin
         run_rx[i] = v[i];
         run_tx[i] = v[i + NCH];
      end
   endtask

   task automatic clear_inputs();
      clear_strobes();
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         set_addr[s]   = '0;
         set_data[s]   = '0;
         rb_addr[s]    = '0;
         misc_in[s]    = '0;
         db_gpio_in[s] = '0;
      end
      set_run_flags('0);
      fp_gpio_in    = '0;
      core_set_addr = '0;
      core_set_data = '0;
   endtask

   // hold the driven values over one rising edge, then drop the strobes
   task automatic step();
      @(posedge radio_clk);
      #1;
      clear_strobes();
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) step();
   endtask

   task automatic slot_write(input int s, input set_addr_t addr, input set_data_t data);
      set_stb[s]  = 1'b1;
      set_addr[s] = addr;
      set_data[s] = data;
   endtask

   task automatic plain_write(input int s);
      logic [2:0] pick;
      pick = 3'(random_bits(3));
      case (pick)
         3'd0:       slot_write(s, SR_DB_BASE + SR_MISC_OUT, random_bits(32));
         3'd1:       slot_write(s, SR_DB_BASE + SR_GPIO_DDR, random_bits(32));
         3'd2:       slot_write(s, SR_DB_BASE + SR_FP_OUT, random_bits(32));
         3'd3:       slot_write(s, SR_DB_BASE + SR_FP_DDR, random_bits(32));
         3'd4, 3'd5: slot_write(s, set_addr_t'(random_bits(8)), random_bits(32));
         3'd6:       slot_write(s, SR_DB_BASE + 8'd12 + set_addr_t'(random_bits(2)),
                                random_bits(32));   // just past the map
         default:    ;
      endcase
   endtask

   task automatic rb_request(input int s);
      logic [2:0] pick;
      pick = 3'(random_bits(3));
      rb_stb[s]  = (pick != 3'd7);
      rb_addr[s] = (pick == 3'd6) ? set_addr_t'(random_bits(8))
                                  : RB_DB_BASE + set_addr_t'(random_bits(3));
   endtask

   task automatic core_write();
      core_set_stb  = 1'b1;
      core_set_addr = (random_bits(2) == 0) ? set_addr_t'(random_bits(8)) : SR_FP_GPIO_SRC;
      core_set_data = random_bits(32);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("test %0d, %s: %0d checks, %0d mismatches", tests_run, name,
               checks - checks_mark, errors - errors_mark);
      checks_mark = checks;
      errors_mark = errors;
   endtask

   initial begin
      clear_inputs();
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge radio_clk);
      #1;
      rst_n = 1'b1;
      idle_cycles(4);                    // no requests so o_rb_stb must stay low
      end_test("reset state");

      for (int r = 0; r < 8; r++) begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            slot_write(s, SR_DB_BASE + atr_offset(r), random_bits(32));
         end
         step();
      end
      for (int n = 0; n < ATR_RUNS; n++) begin
         set_run_flags(random_bits(2 * NCH));
         slot_write(int'(random_bits(1)), SR_DB_BASE + atr_offset(int'(random_bits(3))),
                    random_bits(32));
         step();
         idle_cycles(2);
      end
      end_test("atr selection");

      for (int n = 0; n < PLAIN_CYCLES; n++) begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            plain_write(s);
         end
         step();
      end
      idle_cycles(3);
      end_test("plain registers");

      // back-to-back requests while the sources keep moving
      for (int n = 0; n < RB_CYCLES; n++) begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            rb_request(s);
            misc_in[s]    = random_bits(32);
            db_gpio_in[s] = random_bits(32);
         end
         fp_gpio_in = random_bits(32);
         if (n % 8 == 0) begin
            set_run_flags(random_bits(2 * NCH));
         end
         step();
      end
      idle_cycles(3);
      end_test("readback");

      for (int n = 0; n < FP_RUNS; n++) begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            slot_write(s, SR_DB_BASE + SR_FP_OUT, random_bits(32));
         end
         step();
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            slot_write(s, SR_DB_BASE + SR_FP_DDR, random_bits(32));
         end
         core_write();
         step();
         idle_cycles(2);
      end
      end_test("fp source mux");

      @(negedge radio_clk);
      #1;                                // last compare has settled
      $display("%0d tests, %0d checks, %0d mismatches", tests_run, checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== radio_ctrl_checker.sv ====
`timescale 1ns/1ps

module radio_ctrl_checker #(
   parameter radio_ctrl_pkg::set_addr_t SR_BASE = radio_ctrl_pkg::SR_DB_BASE,
   parameter radio_ctrl_pkg::set_addr_t RB_BASE = radio_ctrl_pkg::RB_DB_BASE,
   parameter int                        FP_PINS = radio_ctrl_pkg::FP_GPIO_PINS
) (
   input  logic                      radio_clk,
   input  logic                      i_rst_n,
   input  logic                      i_set_stb      [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_addr_t i_set_addr     [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_data_t i_set_data     [radio_ctrl_pkg::NUM_DBOARDS],
   input  logic                      i_rb_stb       [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_addr_t i_rb_addr      [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_data_t i_misc_in      [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::gpio_t     i_db_gpio_in   [radio_ctrl_pkg::NUM_DBOARDS],
   input  logic i_run_rx [radio_ctrl_pkg::NUM_DBOARDS*radio_ctrl_pkg::CHANS_PER_DBOARD],
   input  logic i_run_tx [radio_ctrl_pkg::NUM_DBOARDS*radio_ctrl_pkg::CHANS_PER_DBOARD],
   input  radio_ctrl_pkg::gpio_t     i_fp_gpio_in,
   input  logic                      i_core_set_stb,
   input  radio_ctrl_pkg::set_addr_t i_core_set_addr,
   input  radio_ctrl_pkg::set_data_t i_core_set_data,
   // DUT outputs under observation
   input  logic                      i_dut_rb_stb   [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_data_t i_dut_rb_data  [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_data_t i_dut_misc_out [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::gpio_t     i_dut_gpio_out [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::gpio_t     i_dut_gpio_ddr [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::led_t      i_dut_leds     [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::gpio_t     i_dut_fp_out,
   input  radio_ctrl_pkg::gpio_t     i_dut_fp_ddr,
   output int                        o_errors,
   output int                        o_checks
);
   import radio_ctrl_pkg::*;

   set_data_t  m_sreg [NUM_DBOARDS][16];   // slot settings, indexed by offset
   set_data_t  m_misc_out [NUM_DBOARDS];
   set_data_t  m_misc_in [NUM_DBOARDS];
   logic [1:0] m_state [NUM_DBOARDS];      // {tx, rx}
   gpio_t      m_gpio_out [NUM_DBOARDS];
   led_t       m_leds [NUM_DBOARDS];
   logic       m_rb_stb [NUM_DBOARDS];
   set_data_t  m_rb_data [NUM_DBOARDS];
   set_data_t  m_fp_src;
   gpio_t      m_fp_out;
   gpio_t      m_fp_ddr;
   bit         started = 1'b0;
   int         errors = 0;
   int         checks = 0;

   assign o_errors = errors;
   assign o_checks = checks;

   function automatic set_data_t rb_expect(input int s, input set_addr_t addr);
      set_addr_t off;
      off = addr - RB_BASE;
      case (off)
         RB_MISC_IN:    return m_misc_in[s];
         RB_DB_GPIO_IN: return i_db_gpio_in[s];
         RB_FP_GPIO_IN: return i_fp_gpio_in;
         RB_GPIO_OUT:   return m_gpio_out[s];
         default:       return '0;
      endcase
   endfunction

   // two bits per pin, zero picks slot 0, pins past FP_PINS low
   function automatic gpio_t fp_pick(input set_data_t src, input gpio_t s0, input gpio_t s1);
      gpio_t v;
      v = '0;
      for (int p = 0; p < FP_PINS; p++) begin
         v[p] = (src[2*p +: 2] == 2'd0) ? s0[p] : s1[p];
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   // ------------------------------------------------------------------------
   // cycle model, updated on the same edge as the DUT
   // ------------------------------------------------------------------------
   always @(posedge radio_clk) begin
      set_addr_t  off;
      logic [3:0] idx;
      logic       any_rx;
      logic       any_tx;
      started <= 1'b1;
      if (!i_rst_n) begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            for (int r = 0; r < 16; r++) begin
               m_sreg[s][r] <= '0;
            end
            m_misc_out[s] <= '0;
            m_misc_in[s]  <= '0;
            m_state[s]    <= 2'b00;
            m_gpio_out[s] <= '0;
            m_leds[s]     <= '0;
            m_rb_stb[s]   <= 1'b0;
            m_rb_data[s]  <= '0;
         end
         m_fp_src <= '0;
         m_fp_out <= '0;
         m_fp_ddr <= '0;
      end else begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            off = i_set_addr[s] - SR_BASE;
            idx = off[3:0];
            if (i_set_stb[s] && off < 8'd12) begin
               // led registers keep only three bits
               m_sreg[s][idx] <= (idx >= 4'd6 && idx <= 4'd9) ?
                                 {29'd0, i_set_data[s][2:0]} : i_set_data[s];
            end
            any_rx = 1'b0;
            any_tx = 1'b0;
            for (int c = 0; c < CHANS_PER_DBOARD; c++) begin
               any_rx = any_rx | i_run_rx[s*CHANS_PER_DBOARD + c];
               any_tx = any_tx | i_run_tx[s*CHANS_PER_DBOARD + c];
            end
            m_state[s]    <= {any_tx, any_rx};
            m_gpio_out[s] <= m_sreg[s][4'd1 + {2'b00, m_state[s]}];
            m_leds[s]     <= m_sreg[s][4'd6 + {2'b00, m_state[s]}][LED_W-1:0];
            m_misc_out[s] <= m_sreg[s][0];     // second stage towards the pins
            m_misc_in[s]  <= i_misc_in[s];
            m_rb_stb[s]   <= i_rb_stb[s];
            m_rb_data[s]  <= rb_expect(s, i_rb_addr[s]);
         end
         if (i_core_set_stb && i_core_set_addr == SR_FP_GPIO_SRC) begin
            m_fp_src <= i_core_set_data;
         end
         m_fp_out <= fp_pick(m_fp_src, m_sreg[0][10], m_sreg[1][10]);
         m_fp_ddr <= fp_pick(m_fp_src, m_sreg[0][11], m_sreg[1][11]);
      end
   end

   // outputs are settled mid-cycle
   always @(negedge radio_clk) begin
      if (started) begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            check_value($sformatf("o_misc_out[%0d]", s), m_misc_out[s], i_dut_misc_out[s]);
            check_value($sformatf("o_db_gpio_out[%0d]", s), m_gpio_out[s], i_dut_gpio_out[s]);
            check_value($sformatf("o_db_gpio_ddr[%0d]", s), m_sreg[s][5], i_dut_gpio_ddr[s]);
            check_value($sformatf("o_leds[%0d]", s), 32'(m_leds[s]), 32'(i_dut_leds[s]));
            check_value($sformatf("o_rb_stb[%0d]", s), 32'(m_rb_stb[s]), 32'(i_dut_rb_stb[s]));
            if (m_rb_stb[s]) begin
               check_value($sformatf("o_rb_data[%0d]", s), m_rb_data[s], i_dut_rb_data[s]);
            end
         end
         check_value("o_fp_gpio_out", m_fp_out, i_dut_fp_out);
         check_value("o_fp_gpio_ddr", m_fp_ddr, i_dut_fp_ddr);
      end
   end

endmodule

// ==== radio_ctrl_core.sv ====
`timescale 1ns/1ps

module radio_ctrl_core #(
   parameter radio_ctrl_pkg::set_addr_t SR_BASE = radio_ctrl_pkg::SR_DB_BASE,
   parameter radio_ctrl_pkg::set_addr_t RB_BASE = radio_ctrl_pkg::RB_DB_BASE,
   parameter int                        FP_PINS = radio_ctrl_pkg::FP_GPIO_PINS
) (
   input  logic                      radio_clk,
   input  logic                      i_rst_n,
   // per-slot settings and readback
   input  logic                      i_set_stb     [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_addr_t i_set_addr    [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_data_t i_set_data    [radio_ctrl_pkg::NUM_DBOARDS],
   input  logic                      i_rb_stb      [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::set_addr_t i_rb_addr     [radio_ctrl_pkg::NUM_DBOARDS],
   output logic                      o_rb_stb      [radio_ctrl_pkg::NUM_DBOARDS],
   output radio_ctrl_pkg::set_data_t o_rb_data     [radio_ctrl_pkg::NUM_DBOARDS],
   // per-slot pins
   input  radio_ctrl_pkg::set_data_t i_misc_in     [radio_ctrl_pkg::NUM_DBOARDS],
   output radio_ctrl_pkg::set_data_t o_misc_out    [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::gpio_t     i_db_gpio_in  [radio_ctrl_pkg::NUM_DBOARDS],
   output radio_ctrl_pkg::gpio_t     o_db_gpio_out [radio_ctrl_pkg::NUM_DBOARDS],
   output radio_ctrl_pkg::gpio_t     o_db_gpio_ddr [radio_ctrl_pkg::NUM_DBOARDS],
   output radio_ctrl_pkg::led_t      o_leds        [radio_ctrl_pkg::NUM_DBOARDS],
   // channel run flags, two channels per slot
   input  logic i_run_rx [radio_ctrl_pkg::NUM_DBOARDS*radio_ctrl_pkg::CHANS_PER_DBOARD],
   input  logic i_run_tx [radio_ctrl_pkg::NUM_DBOARDS*radio_ctrl_pkg::CHANS_PER_DBOARD],
   // front panel
   input  radio_ctrl_pkg::gpio_t     i_fp_gpio_in,
   output radio_ctrl_pkg::gpio_t     o_fp_gpio_out,
   output radio_ctrl_pkg::gpio_t     o_fp_gpio_ddr,
   input  logic                      i_core_set_stb,
   input  radio_ctrl_pkg::set_addr_t i_core_set_addr,
   input  radio_ctrl_pkg::set_data_t i_core_set_data
);
   import radio_ctrl_pkg::*;

   gpio_t slot_fp_out [NUM_DBOARDS];
   gpio_t slot_fp_ddr [NUM_DBOARDS];

   for (genvar s = 0; s < NUM_DBOARDS; s++) begin : gen_slot
      logic run_rx [CHANS_PER_DBOARD];
      logic run_tx [CHANS_PER_DBOARD];

      // channel pair of this slot
      for (genvar c = 0; c < CHANS_PER_DBOARD; c++) begin : gen_chan
         assign run_rx[c] = i_run_rx[s*CHANS_PER_DBOARD + c];
         assign run_tx[c] = i_run_tx[s*CHANS_PER_DBOARD + c];
      end

      db_slot #(.SR_BASE(SR_BASE), .RB_BASE(RB_BASE)) db_slot_inst (
         .radio_clk(radio_clk), .i_rst_n(i_rst_n),
         .i_set_stb(i_set_stb[s]), .i_set_addr(i_set_addr[s]), .i_set_data(i_set_data[s]),
         .i_rb_stb(i_rb_stb[s]), .i_rb_addr(i_rb_addr[s]),
         .o_rb_stb(o_rb_stb[s]), .o_rb_data(o_rb_data[s]),
         .i_run_rx(run_rx), .i_run_tx(run_tx),
         .i_misc_in(i_misc_in[s]), .o_misc_out(o_misc_out[s]),
         .i_db_gpio_in(i_db_gpio_in[s]), .o_db_gpio_out(o_db_gpio_out[s]),
         .o_db_gpio_ddr(o_db_gpio_ddr[s]),
         .i_fp_gpio_in(i_fp_gpio_in),          // every slot sees the whole panel
         .o_fp_out(slot_fp_out[s]), .o_fp_ddr(slot_fp_ddr[s]),
         .o_leds(o_leds[s])
      );
   end

   fp_gpio_mux #(.NUM_PINS(FP_PINS)) fp_gpio_mux_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_core_set_stb), .i_set_addr(i_core_set_addr),
      .i_set_data(i_core_set_data),
      .i_slot_fp_out(slot_fp_out), .i_slot_fp_ddr(slot_fp_ddr),
      .o_fp_gpio_out(o_fp_gpio_out), .o_fp_gpio_ddr(o_fp_gpio_ddr)
   );

endmodule

// ==== fp_gpio_mux.sv ====
`timescale 1ns/1ps

module fp_gpio_mux #(
   parameter int NUM_PINS = radio_ctrl_pkg::FP_GPIO_PINS
) (
   input  logic                      radio_clk,
   input  logic                      i_rst_n,
   input  logic                      i_set_stb,
   input  radio_ctrl_pkg::set_addr_t i_set_addr,
   input  radio_ctrl_pkg::set_data_t i_set_data,
   input  radio_ctrl_pkg::gpio_t     i_slot_fp_out [radio_ctrl_pkg::NUM_DBOARDS],
   input  radio_ctrl_pkg::gpio_t     i_slot_fp_ddr [radio_ctrl_pkg::NUM_DBOARDS],
   output radio_ctrl_pkg::gpio_t     o_fp_gpio_out,
   output radio_ctrl_pkg::gpio_t     o_fp_gpio_ddr
);
   import radio_ctrl_pkg::*;

   logic [2*NUM_PINS-1:0] fp_src;      // two select bits per pin
   gpio_t                 next_out;
   gpio_t                 next_ddr;

   // ------------------------------------------------------------------------
   // source register on the core settings bus
   // ------------------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         fp_src <= '0;                  // every pin owned by slot 0
      end else if (i_set_stb && (i_set_addr == SR_FP_GPIO_SRC)) begin
         fp_src <= i_set_data[2*NUM_PINS-1:0];
      end
   end

   // ------------------------------------------------------------------------
   // per-pin select, only slots 0 and 1 exist so any nonzero code means slot 1
   // ------------------------------------------------------------------------
   always_comb begin
      next_out = '0;                    // pins past NUM_PINS stay low
      next_ddr = '0;
      for (int p = 0; p < NUM_PINS; p++) begin
         if (fp_src[2*p +: 2] == 2'd0) begin
            next_out[p] = i_slot_fp_out[0][p];
            next_ddr[p] = i_slot_fp_ddr[0][p];
         end else begin
            next_out[p] = i_slot_fp_out[1][p];
            next_ddr[p] = i_slot_fp_ddr[1][p];
         end
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         o_fp_gpio_out <= next_out;
         o_fp_gpio_ddr <= next_ddr;
      end
   end

endmodule

// ==== db_slot.sv ====
`timescale 1ns/1ps

module db_slot #(
   parameter radio_ctrl_pkg::set_addr_t SR_BASE = radio_ctrl_pkg::SR_DB_BASE,
   parameter radio_ctrl_pkg::set_addr_t RB_BASE = radio_ctrl_pkg::RB_DB_BASE
) (
   input  logic                      radio_clk,
   input  logic                      i_rst_n,
   input  logic                      i_set_stb,
   input  radio_ctrl_pkg::set_addr_t i_set_addr,
   input  radio_ctrl_pkg::set_data_t i_set_data,
   input  logic                      i_rb_stb,
   input  radio_ctrl_pkg::set_addr_t i_rb_addr,
   output logic                      o_rb_stb,
   output radio_ctrl_pkg::set_data_t o_rb_data,
   input  logic                      i_run_rx [radio_ctrl_pkg::CHANS_PER_DBOARD],
   input  logic                      i_run_tx [radio_ctrl_pkg::CHANS_PER_DBOARD],
   input  radio_ctrl_pkg::set_data_t i_misc_in,
   output radio_ctrl_pkg::set_data_t o_misc_out,
   input  radio_ctrl_pkg::gpio_t     i_db_gpio_in,
   output radio_ctrl_pkg::gpio_t     o_db_gpio_out,
   output radio_ctrl_pkg::gpio_t     o_db_gpio_ddr,
   input  radio_ctrl_pkg::gpio_t     i_fp_gpio_in,
   output radio_ctrl_pkg::gpio_t     o_fp_out,
   output radio_ctrl_pkg::gpio_t     o_fp_ddr,
   output radio_ctrl_pkg::led_t      o_leds
);
   import radio_ctrl_pkg::*;

   gpio_t      gpio_atr [4];
   led_t       led_atr [4];
   set_data_t  misc_out_q;     // straight from the register bank
   set_data_t  misc_in_r;
   logic       any_rx;
   logic       any_tx;
   atr_state_t run_state;

   // one slot shares a single atr state between both channels
   always_comb begin
      any_rx = 1'b0;
      any_tx = 1'b0;
      for (int c = 0; c < CHANS_PER_DBOARD; c++) begin
         any_rx = any_rx | i_run_rx[c];
         any_tx = any_tx | i_run_tx[c];
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         run_state  <= IDLE;
         misc_in_r  <= '0;
         o_misc_out <= '0;
      end else begin
         run_state  <= atr_state_t'({any_tx, any_rx});
         misc_in_r  <= i_misc_in;
         o_misc_out <= misc_out_q;   // extra stage towards the pins
      end
   end

   db_setting_regs #(.SR_BASE(SR_BASE)) db_setting_regs_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_gpio_atr(gpio_atr), .o_led_atr(led_atr), .o_gpio_ddr(o_db_gpio_ddr),
      .o_misc_out(misc_out_q), .o_fp_out(o_fp_out), .o_fp_ddr(o_fp_ddr)
   );

   atr_select #(.payload_t(gpio_t)) atr_gpio_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n), .i_state(run_state),
      .i_idle(gpio_atr[IDLE]), .i_rx(gpio_atr[RX_ONLY]),
      .i_tx(gpio_atr[TX_ONLY]), .i_fdx(gpio_atr[FULL_DUPLEX]), .o_value(o_db_gpio_out)
   );

   atr_select #(.payload_t(led_t)) atr_led_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n), .i_state(run_state),
      .i_idle(led_atr[IDLE]), .i_rx(led_atr[RX_ONLY]),
      .i_tx(led_atr[TX_ONLY]), .i_fdx(led_atr[FULL_DUPLEX]), .o_value(o_leds)
   );

   db_readback #(.RB_BASE(RB_BASE)) db_readback_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_rb_stb(i_rb_stb), .i_rb_addr(i_rb_addr),
      .i_misc_in(misc_in_r), .i_db_gpio_in(i_db_gpio_in),
      .i_fp_gpio_in(i_fp_gpio_in), .i_gpio_out(o_db_gpio_out),
      .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data)
   );

endmodule

// ==== db_readback.sv ====
`timescale 1ns/1ps

module db_readback #(
   parameter radio_ctrl_pkg::set_addr_t RB_BASE = radio_ctrl_pkg::RB_DB_BASE
) (
   input  logic                      radio_clk,
   input  logic                      i_rst_n,
   input  logic                      i_rb_stb,
   input  radio_ctrl_pkg::set_addr_t i_rb_addr,
   input  radio_ctrl_pkg::set_data_t i_misc_in,
   input  radio_ctrl_pkg::gpio_t     i_db_gpio_in,
   input  radio_ctrl_pkg::gpio_t     i_fp_gpio_in,
   input  radio_ctrl_pkg::gpio_t     i_gpio_out,
   output logic                      o_rb_stb,
   output radio_ctrl_pkg::set_data_t o_rb_data
);
   import radio_ctrl_pkg::*;

   set_addr_t rb_offset;
   set_data_t rb_mux;

   assign rb_offset = i_rb_addr - RB_BASE;

   always_comb begin
      case (rb_offset)
         RB_MISC_IN:    rb_mux = i_misc_in;
         RB_DB_GPIO_IN: rb_mux = i_db_gpio_in;
         RB_FP_GPIO_IN: rb_mux = i_fp_gpio_in;
         RB_GPIO_OUT:   rb_mux = i_gpio_out;   // what the atr stage drives now
         default:       rb_mux = '0;
      endcase
   end

   // one stage, a new request may follow every cycle
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb  <= i_rb_stb;
         o_rb_data <= rb_mux;
      end
   end

   a_rb_answer : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_rb_stb |=> o_rb_stb) else $error("readback request without answer");
   a_rb_spurious : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      !i_rb_stb |=> !o_rb_stb) else $error("readback answer without request");

endmodule

// ==== atr_select.sv ====
`timescale 1ns/1ps

module atr_select #(
   parameter type payload_t = logic
) (
   input  logic                       radio_clk,
   input  logic                       i_rst_n,
   input  radio_ctrl_pkg::atr_state_t i_state,
   input  payload_t                   i_idle,
   input  payload_t                   i_rx,
   input  payload_t                   i_tx,
   input  payload_t                   i_fdx,
   output payload_t                   o_value
);
   import radio_ctrl_pkg::*;

   payload_t chosen;

   // pick the value that belongs to the current run state
   always_comb begin
      case (i_state)
         RX_ONLY:     chosen = i_rx;
         TX_ONLY:     chosen = i_tx;
         FULL_DUPLEX: chosen = i_fdx;
         default:     chosen = i_idle;
      endcase
   end

   // registered so the pins never see the mux settle
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_value <= '0;
      end else begin
         o_value <= chosen;
      end
   end

endmodule

// ==== db_setting_regs.sv ====
`timescale 1ns/1ps

module db_setting_regs #(
   parameter radio_ctrl_pkg::set_addr_t SR_BASE = radio_ctrl_pkg::SR_DB_BASE
) (
   input  logic                      radio_clk,
   input  logic                      i_rst_n,
   input  logic                      i_set_stb,
   input  radio_ctrl_pkg::set_addr_t i_set_addr,
   input  radio_ctrl_pkg::set_data_t i_set_data,
   output radio_ctrl_pkg::gpio_t     o_gpio_atr [4],
   output radio_ctrl_pkg::led_t      o_led_atr [4],
   output radio_ctrl_pkg::gpio_t     o_gpio_ddr,
   output radio_ctrl_pkg::set_data_t o_misc_out,
   output radio_ctrl_pkg::gpio_t     o_fp_out,
   output radio_ctrl_pkg::gpio_t     o_fp_ddr
);
   import radio_ctrl_pkg::*;

   set_addr_t reg_offset;

   // modulo subtraction, so addresses below the base land on large offsets and miss
   assign reg_offset = i_set_addr - SR_BASE;

   // ------------------------------------------------------------------------
   // register bank, atr arrays are indexed by atr_state_t
   // ------------------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_gpio_atr <= '{default: '0};
         o_led_atr  <= '{default: '0};
         o_gpio_ddr <= '0;
         o_misc_out <= '0;
         o_fp_out   <= '0;
         o_fp_ddr   <= '0;
      end else if (i_set_stb) begin
         case (reg_offset)
            SR_MISC_OUT:  o_misc_out <= i_set_data;
            SR_GPIO_IDLE: o_gpio_atr[IDLE] <= i_set_data[GPIO_W-1:0];
            SR_GPIO_RX:   o_gpio_atr[RX_ONLY] <= i_set_data[GPIO_W-1:0];
            SR_GPIO_TX:   o_gpio_atr[TX_ONLY] <= i_set_data[GPIO_W-1:0];
            SR_GPIO_FDX:  o_gpio_atr[FULL_DUPLEX] <= i_set_data[GPIO_W-1:0];
            SR_GPIO_DDR:  o_gpio_ddr <= i_set_data[GPIO_W-1:0];
            SR_LED_IDLE:  o_led_atr[IDLE] <= i_set_data[LED_W-1:0];
            SR_LED_RX:    o_led_atr[RX_ONLY] <= i_set_data[LED_W-1:0];
            SR_LED_TX:    o_led_atr[TX_ONLY] <= i_set_data[LED_W-1:0];
            SR_LED_FDX:   o_led_atr[FULL_DUPLEX] <= i_set_data[LED_W-1:0];
            SR_FP_OUT:    o_fp_out <= i_set_data[GPIO_W-1:0];
            SR_FP_DDR:    o_fp_ddr <= i_set_data[GPIO_W-1:0];
            default: ;                        // not ours, ignore
         endcase
      end
   end

   // an unknown address on a strobe would corrupt an arbitrary register
   a_set_addr_known : assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      i_set_stb |-> !$isunknown(i_set_addr)
   ) else $error("settings strobe with unknown address");

endmodule

// ==== radio_ctrl_pkg.sv ====
package radio_ctrl_pkg;

   // ------------------------------------------------------------------------
   // sizes
   // ------------------------------------------------------------------------
   localparam int NUM_DBOARDS      = 2;
   localparam int CHANS_PER_DBOARD = 2;
   localparam int SET_ADDR_W       = 8;
   localparam int SET_DATA_W       = 32;
   localparam int GPIO_W           = 32;
   localparam int LED_W            = 3;   // {rx, txrx_tx, txrx_rx}
   localparam int FP_GPIO_PINS     = 12;

   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;
   typedef logic [GPIO_W-1:0]     gpio_t;
   typedef logic [LED_W-1:0]      led_t;

   // tx is bit 1, rx is bit 0
   typedef enum logic [1:0] {
      IDLE        = 2'b00,
      RX_ONLY     = 2'b01,
      TX_ONLY     = 2'b10,
      FULL_DUPLEX = 2'b11
   } atr_state_t;

   // ------------------------------------------------------------------------
   // settings and readback map, offsets relative to the slot base
   // ------------------------------------------------------------------------
   localparam set_addr_t SR_DB_BASE = 8'd160;
   localparam set_addr_t SR_MISC_OUT = 8'd0, SR_GPIO_IDLE = 8'd1, SR_GPIO_RX = 8'd2;
   localparam set_addr_t SR_GPIO_TX = 8'd3, SR_GPIO_FDX = 8'd4, SR_GPIO_DDR = 8'd5;
   localparam set_addr_t SR_LED_IDLE = 8'd6, SR_LED_RX = 8'd7, SR_LED_TX = 8'd8;
   localparam set_addr_t SR_LED_FDX = 8'd9, SR_FP_OUT = 8'd10, SR_FP_DDR = 8'd11;
   localparam set_addr_t RB_DB_BASE = 8'd16;
   localparam set_addr_t RB_MISC_IN = 8'd0, RB_DB_GPIO_IN = 8'd1;
   localparam set_addr_t RB_FP_GPIO_IN = 8'd2, RB_GPIO_OUT = 8'd3;
   localparam set_addr_t SR_FP_GPIO_SRC = 8'd50;   // on the core settings bus

endpackage
